// File: cps2_decrypt_top.f
+incdir+verification
rtl/cps2_pkg.sv
rtl/cps2_keyload.sv
rtl/cps2_keystream.sv
rtl/cps2_fetch_gate.sv
rtl/cps2_fetch_mux.sv
rtl/cps2_decrypt_top.sv
verification/cps2_decrypt_tb.sv

// File: rtl/cps2_decrypt_top.sv
// Top level of the opcode decrypt path
// Key loader, keystream generator, fetch gate and output combiner
// Fixed latency of 5 cycles from accept to dout_valid

`timescale 1ns/1ps

module cps2_decrypt_top #(
    parameter bit BETA_SUPPORT = 1'b0
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [7:0]                   din,
    input  logic                         din_we,
    input  logic                         fetch_valid,
    output logic                         fetch_ready,
    input  logic [cps2_pkg::ADDR_W-1:0]  fetch_addr,
    input  cps2_pkg::fetch_kind_e        fetch_kind,
    input  logic [cps2_pkg::DATA_W-1:0]  fetch_data,
    output logic [cps2_pkg::DATA_W-1:0]  dout,
    output logic                         dout_valid,
    output logic                         key_ready
);

    logic [cps2_pkg::KEY_W-1:0]   key;
    logic [cps2_pkg::RNG_W-1:0]   addr_rng;
    logic                         start;
    logic [cps2_pkg::DATA_W-1:0]  mask;
    logic                         mask_done;
    logic [cps2_pkg::DATA_W-1:0]  word;         // Captured encrypted word
    logic                         decrypt_en;
    logic                         done;

    cps2_keyload #(
        .BETA_SUPPORT (BETA_SUPPORT)
    ) i_cps2_keyload (
        .clk       (clk),
        .rst       (rst),
        .din       (din),
        .din_we    (din_we),
        .key       (key),
        .addr_rng  (addr_rng),
        .key_ready (key_ready)
    );

    cps2_keystream i_cps2_keystream (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .fetch_addr (fetch_addr),   // Sampled on start
        .key        (key),
        .mask       (mask),
        .mask_done  (mask_done)
    );

    cps2_fetch_gate i_cps2_fetch_gate (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch_addr  (fetch_addr),
        .fetch_kind  (fetch_kind),
        .fetch_data  (fetch_data),
        .addr_rng    (addr_rng),
        .key_ready   (key_ready),
        .done        (done),
        .start       (start),
        .word        (word),
        .decrypt_en  (decrypt_en)
    );

    cps2_fetch_mux i_cps2_fetch_mux (
        .clk        (clk),
        .rst        (rst),
        .mask       (mask),
        .mask_done  (mask_done),
        .word       (word),
        .decrypt_en (decrypt_en),
        .dout       (dout),
        .dout_valid (dout_valid),
        .done       (done)
    );

endmodule

// File: rtl/cps2_fetch_gate.sv
// Fetch gate
// Valid/ready handshake with single fetch in flight
// Word capture and decrypt decision (key loaded, opcode, address in range)

`timescale 1ns/1ps

module cps2_fetch_gate (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         fetch_valid,
    output logic                         fetch_ready,
    input  logic [cps2_pkg::ADDR_W-1:0]  fetch_addr,
    input  cps2_pkg::fetch_kind_e        fetch_kind,
    input  logic [cps2_pkg::DATA_W-1:0]  fetch_data,
    input  logic [cps2_pkg::RNG_W-1:0]   addr_rng,
    input  logic                         key_ready,
    input  logic                         done,
    output logic                         start,
    output logic [cps2_pkg::DATA_W-1:0]  word,
    output logic                         decrypt_en
);

    logic busy;         // Accept until done
    logic in_range;
    logic need_dec;

    assign fetch_ready = !busy;
    assign start       = fetch_valid && fetch_ready;   // Accept pulse

    // Upper address bits against the loaded limit
    assign in_range = fetch_addr[cps2_pkg::ADDR_W-1 -: cps2_pkg::RNG_W] <= addr_rng;
    assign need_dec = key_ready
                   && (fetch_kind == cps2_pkg::FETCH_OPCODE)
                   && in_range;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
        end else begin
            if (start)
                busy <= 1'b1;
            else if (done)
                busy <= 1'b0;       // Ready again next cycle
        end
    end

    // Held for the combiner until the mask is ready
    always_ff @(posedge clk) begin
        if (start) begin
            word       <= fetch_data;
            decrypt_en <= need_dec;
        end
    end

    // Combiner answers only for an accepted fetch
    a_done_while_busy: assert property (
        @(posedge clk) disable iff (rst) done |-> busy
    );

endmodule

// File: rtl/cps2_fetch_mux.sv
// Output combiner
// Applies the mask to opcode words or passes data words as read
// Registered result with one-cycle valid and done pulses

`timescale 1ns/1ps

module cps2_fetch_mux (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [cps2_pkg::DATA_W-1:0]  mask,
    input  logic                         mask_done,
    input  logic [cps2_pkg::DATA_W-1:0]  word,
    input  logic                         decrypt_en,
    output logic [cps2_pkg::DATA_W-1:0]  dout,
    output logic                         dout_valid,
    output logic                         done
);

    logic [cps2_pkg::DATA_W-1:0] plain;

    assign plain = decrypt_en ? (word ^ mask) : word;  // Bypass outside the range

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            dout_valid <= 1'b0;
        else
            dout_valid <= mask_done;    // Single pulse per fetch
    end

    // Word only moves when a mask completes
    always_ff @(posedge clk) begin
        if (mask_done)
            dout <= plain;
    end

    assign done = dout_valid;           // Frees the gate as the word leaves

endmodule

// File: rtl/cps2_keyload.sv
// Serial key loader
// Edge-detected byte strobe, 160-bit shift register and 12-bit checksum
// Fixed bit permutation into key and address limit
// Beta board key override, key-ready flag

`timescale 1ns/1ps

module cps2_keyload #(
    parameter bit BETA_SUPPORT = 1'b0
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [7:0]                  din,
    input  logic                        din_we,
    output logic [cps2_pkg::KEY_W-1:0]  key,
    output logic [cps2_pkg::RNG_W-1:0]  addr_rng,
    output logic                        key_ready
);

    localparam int RAW_W = cps2_pkg::KEY_BYTES * 8;     // 160 raw bits
    localparam int GRP_N = RAW_W / 16;                  // Permutation groups
    localparam int SUM_W = 12;
    localparam int CNT_W = $clog2(cps2_pkg::KEY_BYTES + 1);
    localparam int BETA_BITS = 10;

    logic             we_l;        // Strobe from last cycle
    logic             byte_take;
    logic [RAW_W-1:0] raw;
    logic [RAW_W-1:0] cfg;
    logic [SUM_W-1:0] sum;
    logic [CNT_W-1:0] byte_cnt;
    logic             known_sum;
    logic             beta_force;

    // Each 16-bit group takes raw bits base+10..15, base+0..7 and the two
    // bits just below the previous group; key groups come in swapped pairs
    function automatic logic [RAW_W-1:0] permute(input logic [RAW_W-1:0] r);
        logic [RAW_W-1:0] p;
        int               base;
        int               src;
        p = '0;
        for (int g = 0; g < GRP_N; g++) begin
            base = (g < 6) ? 16 * g : 16 * (g ^ 1);
            for (int j = 0; j < 16; j++) begin
                if (j < 6)
                    src = base + 10 + j;
                else if (j < 14)
                    src = base + j - 6;
                else
                    src = (base + RAW_W - 8 + j - 14) % RAW_W;  // Wraps for group 0
                p[RAW_W - 1 - 16 * g - j] = r[src];
            end
        end
        return p;
    endfunction

    assign byte_take = din_we && !we_l;     // Rising edge only

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            we_l      <= 1'b0;
            sum       <= '0;
            byte_cnt  <= '0;
            key_ready <= 1'b0;
        end else begin
            we_l <= din_we;
            if (byte_take) begin
                sum <= sum + {{(SUM_W-8){1'b0}}, din};
                if (byte_cnt != CNT_W'(cps2_pkg::KEY_BYTES))
                    byte_cnt <= byte_cnt + 1'b1;                // Saturates
                if (byte_cnt == CNT_W'(cps2_pkg::KEY_BYTES - 1))
                    key_ready <= 1'b1;                          // Sticky until reset
            end
        end
    end

    // New byte enters at the top, oldest falls off the bottom
    always_ff @(posedge clk) begin
        if (byte_take)
            raw <= {din, raw[RAW_W-1:8]};
    end

    // Production board checksums
    always_comb begin
        case (sum)
            12'h7ac, 12'h7d9,
            12'h70c, 12'h6f5, 12'h6eb, 12'h646,
            12'h51c, 12'h5f9, 12'h604, 12'h4c1,
            12'h741,
            12'h647, 12'h628, 12'h4bd,
            12'h747, 12'h666, 12'h6c0, 12'h6cf, 12'h6ed,
            12'h69c: known_sum = 1'b1;
            default: known_sum = 1'b0;
        endcase
    end

    assign beta_force = BETA_SUPPORT && !known_sum;    // Unknown sum means beta board

    assign cfg      = permute(raw);
    assign key      = cfg[cps2_pkg::KEY_W-1:0]
                    | {{(cps2_pkg::KEY_W-BETA_BITS){1'b0}}, {BETA_BITS{beta_force}}};
    assign addr_rng = cfg[RAW_W-1 -: cps2_pkg::RNG_W];   // Top group

    // Once a full key is in, it stays valid
    a_key_ready_sticky: assert property (
        @(posedge clk) disable iff (rst) $past(key_ready) |-> key_ready
    );

endmodule

// File: rtl/cps2_keystream.sv
// Keystream mask generator
// FSM with round counter, one rotate-and-XOR round per cycle
// Mask seeded from the low address bits, mixed with key slices

`timescale 1ns/1ps

module cps2_keystream (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start,
    input  logic [cps2_pkg::ADDR_W-1:0]  fetch_addr,
    input  logic [cps2_pkg::KEY_W-1:0]   key,
    output logic [cps2_pkg::DATA_W-1:0]  mask,
    output logic                         mask_done
);

    localparam int DW    = cps2_pkg::DATA_W;
    localparam int CNT_W = $clog2(cps2_pkg::ROUNDS);
    localparam int HI_W  = 8;           // Upper address bits mixed per round
    localparam int ROT   = 3;

    cps2_pkg::ks_state_e           state;
    logic [CNT_W-1:0]              rnd;        // Current round
    logic [cps2_pkg::ADDR_W-1:0]   addr_q;
    logic [DW-1:0]                 mask_q;     // Mask after previous rounds
    logic [DW-1:0]                 mask_rot;
    logic [DW-1:0]                 key_slice;
    logic [DW-1:0]                 addr_hi;
    logic [DW-1:0]                 mask_nxt;
    logic                          last_rnd;

    // Round function, rotate first then XOR
    assign mask_rot  = {mask_q[DW-ROT-1:0], mask_q[DW-1 -: ROT]};
    assign key_slice = key[rnd * DW +: DW];
    assign addr_hi   = {{(DW-HI_W){1'b0}}, addr_q[cps2_pkg::ADDR_W-1 -: HI_W]};
    assign mask_nxt  = mask_rot ^ key_slice ^ addr_hi;

    assign last_rnd  = (state == cps2_pkg::KS_ROUND) && (rnd == CNT_W'(cps2_pkg::ROUNDS - 1));

    // Final round result goes straight out, taken by the combiner
    assign mask      = mask_nxt;
    assign mask_done = last_rnd;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= cps2_pkg::KS_IDLE;
            rnd   <= '0;
        end else begin
            case (state)
                cps2_pkg::KS_IDLE: begin
                    if (start) begin
                        state <= cps2_pkg::KS_ROUND;
                        rnd   <= '0;
                    end
                end
                cps2_pkg::KS_ROUND: begin
                    rnd <= rnd + 1'b1;                          // Wraps to 0 after last
                    if (last_rnd)
                        state <= cps2_pkg::KS_DONE;
                end
                cps2_pkg::KS_DONE: state <= cps2_pkg::KS_IDLE;  // Gate still busy here
                default: state <= cps2_pkg::KS_IDLE;
            endcase
        end
    end

    // Address and mask seed latched on start
    always_ff @(posedge clk) begin
        if (state == cps2_pkg::KS_IDLE && start) begin
            addr_q <= fetch_addr;
            mask_q <= fetch_addr[DW-1:0];
        end else if (state == cps2_pkg::KS_ROUND) begin
            mask_q <= mask_nxt;
        end
    end

    // Gate must hold off new fetches until the FSM is back
    a_start_in_idle: assert property (
        @(posedge clk) disable iff (rst) start |-> state == cps2_pkg::KS_IDLE
    );

endmodule

// File: rtl/cps2_pkg.sv
// Shared definitions for the CPS2-style opcode decrypt path
// Key loader sizes, fetch port widths and round count
// Fetch kind enum and keystream FSM state enum

package cps2_pkg;

    // Key loader
    localparam int KEY_BYTES = 20;      // Config bytes per key load
    localparam int KEY_W     = 64;      // Permuted key width
    localparam int RNG_W     = 16;      // Address limit width

    // Fetch port
    localparam int ADDR_W    = 24;      // Word address
    localparam int DATA_W    = 16;      // Word width

    // Keystream
    localparam int ROUNDS    = 4;       // One key slice per round

    // Kind of bus cycle behind a fetch
    // Data reads always pass through untouched
    typedef enum logic {
        FETCH_DATA   = 1'b0,
        FETCH_OPCODE = 1'b1
    } fetch_kind_e;

    // Mask generator FSM
    typedef enum logic [1:0] {
        KS_IDLE  = 2'd0,    // Waiting for start
        KS_ROUND = 2'd1,    // One round per cycle
        KS_DONE  = 2'd2     // Recovery cycle before next start
    } ks_state_e;

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the decrypt path testbench with Verilator
set -e
cd "$(dirname "$0")"

TOP=cps2_decrypt_tb
LOG=sim.log

verilator --binary --timing --assert \
    -f cps2_decrypt_top.f \
    --top-module "$TOP" \
    -o "V$TOP"

./obj_dir/"V$TOP" | tee "$LOG"

if grep -qx "TEST PASS" "$LOG"; then
    echo "simulation passed"
else
    echo "simulation failed, see $LOG"
    exit 1
fi

// File: verification/cps2_decrypt_model.svh
// Reference model for the opcode decrypt path
// Raw key register rebuilt from the bytes sent, byte count and checksum
// Key permutation, address range rule and mask rounds
`ifndef CPS2_DECRYPT_MODEL_SVH
`define CPS2_DECRYPT_MODEL_SVH

logic [159:0] m_raw = '0;      // Newest byte on top
logic [11:0]  m_sum = '0;      // Running byte sum
int           m_cnt = 0;       // Bytes since reset

function automatic void model_take(input logic [7:0] b);
    m_raw = {b, m_raw[159:8]};
    m_sum = m_sum + {4'h0, b};
    m_cnt++;
endfunction

function automatic logic [15:0] rev16(input logic [15:0] v);
    logic [15:0] r;
    for (int i = 0; i < 16; i++)
        r[i] = v[15 - i];    // Mirror
    return r;
endfunction

// Group g mirrors {slice below bits 9:8, slice low byte, slice top six bits}
function automatic logic [159:0] model_cfg();
    logic [159:0] c;
    int           s;
    for (int g = 0; g < 10; g++) begin
        s = (g < 6) ? g : (g ^ 1);             // Key slices swapped in pairs
        c[159 - 16 * g -: 16] = rev16({m_raw[16 * ((s + 9) % 10) + 8 +: 2],
                                       m_raw[16 * s +: 8], m_raw[16 * s + 10 +: 6]});
    end
    return c;
endfunction

function automatic logic [15:0] model_mask(input logic [63:0] k, input logic [23:0] a);
    logic [15:0] m;
    m = a[15:0];
    for (int r = 0; r < cps2_pkg::ROUNDS; r++)
        m = {m[12:0], m[15:13]} ^ k[16 * r +: 16] ^ {8'h00, a[23:16]};   // Rotate, then mix
    return m;
endfunction

// Decrypted only with a full key, an opcode and the upper address within the limit
function automatic logic [15:0] model_word(input logic [23:0] a,
                                           input cps2_pkg::fetch_kind_e k,
                                           input logic [15:0] d);
    logic [159:0] c;
    c = model_cfg();
    if (m_cnt >= cps2_pkg::KEY_BYTES && k == cps2_pkg::FETCH_OPCODE
        && a[23:8] <= c[159:144])
        return d ^ model_mask(c[63:0], a);
    return d;
endfunction

`endif

// File: verification/cps2_decrypt_tb.sv
// Testbench for the opcode decrypt path
// Clock, reset, random key loads and fetches checked against the model
// Per-test result lines, closing counts and a cycle limit

`timescale 1ns/1ps

module cps2_decrypt_tb;

    localparam int unsigned SEED  = 32'ha9181fe1;
    localparam int          LIMIT = 3000;   // Two key loads plus 300 fetches, with margin
    localparam int          LAT   = 5;      // Accept to dout_valid

    logic                         clk;
    logic                         rst;
    logic [7:0]                   din;
    logic                         din_we;
    logic                         fetch_valid;
    logic                         fetch_ready;
    logic [cps2_pkg::ADDR_W-1:0]  fetch_addr;
    cps2_pkg::fetch_kind_e        fetch_kind;
    logic [cps2_pkg::DATA_W-1:0]  fetch_data;
    logic [cps2_pkg::DATA_W-1:0]  dout;
    logic                         dout_valid;
    logic                         key_ready;
    int                           errors = 0;
    int                           tests_ok = 0;
    int                           tests_bad = 0;
    int                           cycles = 0;

    `include "cps2_decrypt_model.svh"

    cps2_decrypt_top #(.BETA_SUPPORT(1'b0)) i_cps2_decrypt_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;              // 4 ns
    end

    initial begin
        while (cycles < LIMIT)
            @(posedge clk) cycles++;
        $display("timeout: run still going after %0d cycles", LIMIT);
        $display("TEST FAIL");
        $finish;
    end

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            $display("mismatch at %0t: %s expected %0h got %0h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int err0);
        if (errors == err0) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", name, errors - err0);
        end
    endtask

    // Two cycles per byte so every strobe has a rising edge
    task automatic load_key();
        logic [7:0] b;
        for (int i = 0; i < cps2_pkg::KEY_BYTES; i++) begin
            b = 8'($urandom);
            @(posedge clk);
            din    <= b;
            din_we <= 1'b1;
            @(posedge clk);
            din_we <= 1'b0;                 // Byte taken on this edge
            model_take(b);
        end
        @(negedge clk);
        $display("key load: %0d bytes sent, checksum %h", m_cnt, m_sum);
    endtask

    // Upper bits at or below the limit, or above it when one exists
    function automatic logic [23:0] rand_addr(input bit in_rng);
        logic [159:0] c;
        int unsigned  lim;
        int unsigned  hi;
        c   = model_cfg();
        lim = 32'(c[159:144]);
        if (in_rng || lim == 32'hffff)
            hi = $urandom % (lim + 1);
        else
            hi = lim + 1 + $urandom % (32'hffff - lim);
        return {16'(hi), 8'($urandom)};
    endfunction

    task automatic fetch_one(input logic [23:0] a, input cps2_pkg::fetch_kind_e k);
        logic [15:0] d;
        logic [15:0] exp;
        int          lat;
        d   = 16'($urandom);
        exp = model_word(a, k, d);
        @(posedge clk);
        fetch_valid <= 1'b1;
        fetch_addr  <= a;
        fetch_kind  <= k;
        fetch_data  <= d;
        @(negedge clk);
        check_val("fetch_ready", 32'(1), 32'(fetch_ready));    // Accept cycle
        @(posedge clk);
        fetch_valid <= 1'b0;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
            check_val("fetch_ready", 32'(0), 32'(fetch_ready));    // Busy
        end while (!dout_valid && lat < 2 * LAT);
        check_val("dout_valid latency", 32'(LAT), 32'(lat));
        check_val("dout", 32'(exp), 32'(dout));
        @(negedge clk);
        check_val("dout_valid", 32'(0), 32'(dout_valid));      // One-cycle pulse
        check_val("fetch_ready", 32'(1), 32'(fetch_ready));
    endtask

    // fetch_valid held high, accepts and results tracked by cycle
    task automatic hold_valid(input int n);
        logic [15:0]           exp_q[$];
        int                    acc_q[$];
        logic [23:0]           a;
        cps2_pkg::fetch_kind_e k;
        logic [15:0]           d;
        int                    acc;
        int                    got;
        int                    cyc;
        int                    last;
        acc  = 0;
        got  = 0;
        cyc  = 0;
        last = -LAT - 1;
        a    = rand_addr(1'b1);
        k    = cps2_pkg::fetch_kind_e'(1'($urandom));
        d    = 16'($urandom);
        @(posedge clk);
        fetch_valid <= 1'b1;
        fetch_addr  <= a;
        fetch_kind  <= k;
        fetch_data  <= d;
        while (got < n && cyc < 8 * n + 20) begin
            @(negedge clk);
            cyc++;
            if (dout_valid) begin
                assert (exp_q.size() > 0) else begin
                    $display("dout_valid pulse at %0t without an accepted fetch", $time);
                    errors++;
                end
                if (exp_q.size() > 0) begin
                    check_val("dout", 32'(exp_q.pop_front()), 32'(dout));
                    check_val("dout_valid latency", 32'(LAT), 32'(cyc - acc_q.pop_front()));
                end
                got++;
            end
            if (fetch_valid && fetch_ready) begin
                assert (cyc - last > LAT) else begin
                    $display("fetch accepted %0d cycles after the previous one", cyc - last);
                    errors++;
                end
                exp_q.push_back(model_word(a, k, d));
                acc_q.push_back(cyc);
                last = cyc;
                acc++;
                a = rand_addr(1'($urandom));
                k = cps2_pkg::fetch_kind_e'(1'($urandom));
                d = 16'($urandom);
                @(posedge clk);
                fetch_valid <= (acc < n);   // Drop after the last one
                fetch_addr  <= a;
                fetch_kind  <= k;
                fetch_data  <= d;
            end
        end
        check_val("dout_valid pulses", 32'(acc), 32'(got));
    endtask

    initial begin
        int           err0;
        logic [23:0]  a0;
        logic [15:0]  old_mask;
        logic [159:0] c;
        void'($urandom(SEED));
        rst         <= 1'b1;
        din         <= '0;
        din_we      <= 1'b0;
        fetch_valid <= 1'b0;
        fetch_addr  <= '0;
        fetch_kind  <= cps2_pkg::FETCH_DATA;
        fetch_data  <= '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        err0 = errors;
        check_val("dout_valid", 32'(0), 32'(dout_valid));
        check_val("key_ready", 32'(0), 32'(key_ready));
        check_val("fetch_ready", 32'(1), 32'(fetch_ready));
        finish_test("reset state", err0);

        err0 = errors;
        // Even fetches are opcodes on the lowest page, in range of any limit
        for (int i = 0; i < 20; i++)
            if (i % 2 == 0)
                fetch_one({16'h0000, 8'($urandom)}, cps2_pkg::FETCH_OPCODE);
            else
                fetch_one(24'($urandom), cps2_pkg::fetch_kind_e'(1'($urandom)));
        finish_test("bypass before key load", err0);

        err0 = errors;
        check_val("key_ready", 32'(0), 32'(key_ready));
        load_key();
        check_val("key_ready", 32'(1), 32'(key_ready));
        for (int i = 0; i < 100; i++)
            fetch_one(rand_addr(1'b1), cps2_pkg::FETCH_OPCODE);
        finish_test("decrypt in range", err0);

        err0 = errors;
        for (int i = 0; i < 60; i++)
            if (i % 2 == 0)
                fetch_one(rand_addr(1'b0), cps2_pkg::FETCH_OPCODE);
            else
                fetch_one(rand_addr(1'($urandom)), cps2_pkg::FETCH_DATA);
        finish_test("data and out of range", err0);

        err0 = errors;
        c        = model_cfg();
        a0       = {16'h0000, 8'($urandom)};          // Low page, always in range
        old_mask = model_mask(c[63:0], a0);
        load_key();
        c = model_cfg();
        assert (model_mask(c[63:0], a0) != old_mask) else begin
            $display("new key left the predicted mask unchanged");
            errors++;
        end
        for (int i = 0; i < 80; i++)
            fetch_one(rand_addr(i % 4 != 3), cps2_pkg::fetch_kind_e'(1'(i % 4 != 2)));
        finish_test("key reload", err0);

        err0 = errors;
        hold_valid(40);
        finish_test("valid held high", err0);

        $display("tests passed %0d failed %0d", tests_ok, tests_bad);
        if (tests_bad == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule
